// File: build.f
hw/bus_pkg.sv
hw/mem_bus_if.sv
hw/startup_ram.sv
hw/sram_ctrl.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_port.sv
hw/soc_top.sv
testbench/soc_assertions.sv
testbench/tb_soc.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Mdir obj_dir
TOP      = tb_soc
FILELIST = build.f
SOURCES  = $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/soc_trace.txt
// op addr data expect lat, all hex; op 1 write, 2 read, 3 send, 4 receive, 5 unmapped, f end
// lat is the number of rising edges from the request edge to the edge that raises done
1 00000000 deadbeef 00000000 1
1 000000ff 12345678 00000000 1
1 00000010 a5a5a5a5 00000000 1
2 00000000 00000000 deadbeef 1
2 000000ff 00000000 12345678 1
2 00000010 00000000 a5a5a5a5 1
1 00000100 cafef00d 00000000 4
1 00000101 0badc0de 00000000 4
1 000400ff 76543210 00000000 4
2 00000100 00000000 cafef00d 3
2 00000101 00000000 0badc0de 3
2 000400ff 00000000 76543210 3
3 fffffff0 00000055 00000055 1
3 fffffff0 000000a3 000000a3 1
4 fffffff0 0000003c 0000003c 1
4 fffffff0 000000c1 000000c1 1
5 00100000 00000000 00000000 0
5 80000000 00000000 00000000 0
f 00000000 00000000 00000000 0

// File: testbench/tb_soc.sv
`timescale 1ns/10ps
`default_nettype none

// trace-driven bus master with program sram and serial line models
module tb_soc import bus_pkg::*; ();

  localparam int CLKS_PER_BIT  = DEF_CLK_FREQ / DEF_BAUD;   // 434 at 50 MHz
  localparam int TRACE_W       = 9;
  localparam int BUS_WAIT      = 20;                 // normal access limit
  localparam int HALT_WAIT     = 12 * CLKS_PER_BIT;  // longer than a frame
  localparam int UNMAPPED_WAIT = 50;

  logic       clk;
  logic       rst_n;
  addr_t      addr;
  data_t      wdata;
  logic       read_q;
  logic       write_q;
  data_t      rdata;
  logic       read_dn;
  logic       write_dn;
  logic       rw_halt;
  sram_addr_t sram_addr;
  data_t      sram_wdata;
  data_t      sram_rdata;
  logic       sram_ce_n;
  logic       sram_oe_n;
  logic       sram_we_n;
  logic       sram_drive;
  logic       rxd;
  logic       txd;
  logic       rx_received;

  data_t      trace_mem [2**TRACE_W];   // five words per trace line
  data_t      sram_mem [2**SRAM_ADDR_W];
  logic       ce_n_seen;    // pins half a cycle before a we rise
  logic       drive_seen;   // controller drives the data pins
  sram_addr_t addr_seen;
  data_t      wdata_seen;
  int         errors;
  int         pin_errors;   // from the pin monitor
  int         tests;
  addr_t      last_ext_addr;   // last word written to external sram
  data_t      last_ext_data;

  soc_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .addr        (addr),
    .wdata       (wdata),
    .read_q      (read_q),
    .write_q     (write_q),
    .rdata       (rdata),
    .read_dn     (read_dn),
    .write_dn    (write_dn),
    .rw_halt     (rw_halt),
    .sram_addr   (sram_addr),
    .sram_wdata  (sram_wdata),
    .sram_rdata  (sram_rdata),
    .sram_ce_n   (sram_ce_n),
    .sram_oe_n   (sram_oe_n),
    .sram_we_n   (sram_we_n),
    .sram_drive  (sram_drive),
    .rxd         (rxd),
    .txd         (txd),
    .rx_received (rx_received)
  );

  bind sram_ctrl soc_assertions i_sram_checks (
    .clk        (clk),
    .rst_n      (rst_n),
    .sram_ce_n  (sram_ce_n),
    .sram_we_n  (sram_we_n),
    .sram_drive (sram_drive),
    .read_dn    (read_dn_q),
    .write_dn   (write_dn_q),
    .in_write   (state == ST_WR_SET_ADDR || state == ST_WR_SET_WE ||
                 state == ST_WR_FINISH)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 50 MHz
  end

  // async sram model drives read data only with ce and oe low
  assign sram_rdata = (!sram_ce_n && !sram_oe_n) ? sram_mem[sram_addr] : '0;

  always @(negedge clk) begin
    ce_n_seen  <= sram_ce_n;
    drive_seen <= sram_drive;
    addr_seen  <= sram_addr;
    wdata_seen <= sram_wdata;
  end

  always @(posedge sram_we_n) begin
    if (!ce_n_seen && drive_seen) begin
      sram_mem[addr_seen] <= wdata_seen;   // store on the rising we
    end
  end

  // pin level protocol seen from outside
  always @(negedge clk) begin
    if (rst_n) begin
      assert (!(read_dn && write_dn)) else begin
        $display("read_dn and write_dn high together at %0t", $time);
        pin_errors++;
      end
      assert (sram_we_n || !sram_ce_n) else begin
        $display("sram we_n low without ce_n at %0t", $time);
        pin_errors++;
      end
      assert (!sram_drive || sram_oe_n) else begin
        $display("sram data driven while oe_n low at %0t", $time);
        pin_errors++;
      end
    end
  end

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err0);
    end
  endtask

  // one bus access with the request held as a level until done or limit
  task automatic bus_access(input logic is_write, input addr_t a, input data_t d,
                            input int limit, output logic got, output int lat,
                            output data_t rd, output logic held, output logic halt_dn);
    got     = 1'b0;
    lat     = 0;
    rd      = '0;
    held    = 1'b0;
    halt_dn = 1'b0;
    @(posedge clk);
    addr    <= a;
    wdata   <= d;
    read_q  <= ~is_write;
    write_q <= is_write;
    while (!got && lat < limit) begin
      @(posedge clk);
      lat++;
      @(negedge clk);   // sample away from the edge
      if (read_dn || write_dn) begin
        got     = 1'b1;
        rd      = rdata;
        halt_dn = rw_halt;
      end else if (rw_halt) begin
        held = 1'b1;   // request stalled by the hold
      end
    end
    @(posedge clk);
    read_q  <= 1'b0;
    write_q <= 1'b0;
  endtask

  // mid-bit sampling of one 8n1 frame on txd
  task automatic decode_txd(output byte_t b, output logic framed, output logic halted);
    int i;
    int n;
    b      = '0;
    framed = 1'b0;
    halted = 1'b1;
    n      = 0;
    while (txd !== 1'b0 && n < BUS_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (txd !== 1'b0) begin
      $display("no start bit on txd within %0d cycles", BUS_WAIT);
      errors++;
      halted = 1'b0;
    end else begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      framed = ~txd;
      halted = rw_halt;
      for (i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        b      = {txd, b[7:1]};   // lsb first
        halted = halted & rw_halt;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);   // middle of stop bit
      framed = framed & txd;
      halted = halted & rw_halt;
    end
  endtask

  task automatic drive_rxd(input byte_t b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      rxd <= frame[0];
      frame = frame >> 1;
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic write_word(input string name, input addr_t a, input data_t d,
                            input int exp_lat);
    logic       got;
    int         lat;
    data_t      rd;
    logic       held;
    logic       hd;
    sram_addr_t pin;
    bus_access(1'b1, a, d, BUS_WAIT, got, lat, rd, held, hd);
    if (!got) begin
      $display("%s: no write done within %0d cycles", name, BUS_WAIT);
      errors++;
    end else begin
      check_value({name, " latency"}, data_t'(exp_lat), data_t'(lat));
      if (a >= addr_t'(DEF_INT_MEM_WORDS) && a < addr_t'(DEF_EXT_MEM_END)) begin
        pin = sram_addr_t'(a - addr_t'(DEF_INT_MEM_WORDS));   // sram starts at 0
        check_value({name, " sram array"}, d, sram_mem[pin]);
        last_ext_addr = a;
        last_ext_data = d;
      end
    end
  endtask

  task automatic read_word(input string name, input addr_t a, input data_t exp,
                           input int exp_lat);
    logic  got;
    int    lat;
    data_t rd;
    logic  held;
    logic  hd;
    bus_access(1'b0, a, '0, BUS_WAIT, got, lat, rd, held, hd);
    if (!got) begin
      $display("%s: no read done within %0d cycles", name, BUS_WAIT);
      errors++;
    end else begin
      check_value({name, " latency"}, data_t'(exp_lat), data_t'(lat));
      check_value(name, exp, rd);
    end
  endtask

  // frame out on txd with an sram read stalled behind rw_halt
  task automatic send_byte(input string name, input data_t d, input data_t exp,
                           input int exp_lat);
    logic  got;
    int    lat;
    data_t rd;
    logic  held;
    logic  hd;
    logic  rgot;
    int    rlat;
    data_t rword;
    logic  rheld;
    logic  rhd;
    byte_t b;
    logic  framed;
    logic  halted;
    fork
      decode_txd(b, framed, halted);
      begin
        bus_access(1'b1, DEF_UART_ADDR, d, BUS_WAIT, got, lat, rd, held, hd);
        bus_access(1'b0, last_ext_addr, '0, HALT_WAIT, rgot, rlat, rword, rheld, rhd);
      end
    join
    if (!got) begin
      $display("%s: rs232 port gave no write done", name);
      errors++;
    end else begin
      check_value({name, " latency"}, data_t'(exp_lat), data_t'(lat));
      check_value({name, " rw_halt at done"}, 32'd1, data_t'(hd));
    end
    check_value({name, " framing"}, 32'd1, data_t'(framed));
    check_value(name, exp, data_t'(b));
    check_value({name, " rw_halt over frame"}, 32'd1, data_t'(halted));
    if (!rgot) begin
      $display("%s: sram read under rw_halt never completed", name);
      errors++;
    end else begin
      check_value({name, " read held"}, 32'd1, data_t'(rheld));
      check_value({name, " rw_halt at read done"}, 32'd0, data_t'(rhd));
      check_value({name, " held read"}, last_ext_data, rword);
    end
  endtask

  task automatic receive_byte(input string name, input data_t d, input data_t exp,
                              input int exp_lat);
    logic  got;
    int    lat;
    data_t rd;
    logic  held;
    logic  hd;
    int    n;
    drive_rxd(d[7:0]);
    n = 0;
    while (!rx_received && n < 2 * CLKS_PER_BIT) begin
      @(negedge clk);
      n++;
    end
    if (!rx_received) begin
      $display("%s: rx_received never rose after the frame", name);
      errors++;
    end else begin
      bus_access(1'b0, DEF_UART_ADDR, '0, BUS_WAIT, got, lat, rd, held, hd);
      @(negedge clk);
      if (!got) begin
        $display("%s: rs232 port gave no read done", name);
        errors++;
      end else begin
        check_value({name, " latency"}, data_t'(exp_lat), data_t'(lat));
        check_value(name, exp, rd);   // byte zero extended
        check_value({name, " rx_received"}, 32'd0, data_t'(rx_received));
      end
    end
  endtask

  task automatic probe_unmapped(input string name, input addr_t a, input data_t exp);
    logic  got;
    int    lat;
    data_t rd;
    logic  held;
    logic  hd;
    bus_access(1'b0, a, '0, UNMAPPED_WAIT, got, lat, rd, held, hd);
    check_value({name, " dones"}, exp, data_t'(got));   // nobody answers
  endtask

  initial begin
    logic [TRACE_W-1:0] base;
    data_t              op;
    addr_t              a;
    data_t              d;
    data_t              exp;
    int                 lat;
    int                 err0;
    string              name;
    rst_n         = 1'b0;
    addr          = '0;
    wdata         = '0;
    read_q        = 1'b0;
    write_q       = 1'b0;
    rxd           = 1'b1;   // idle line
    errors        = 0;
    pin_errors    = 0;
    tests         = 0;
    last_ext_addr = addr_t'(DEF_INT_MEM_WORDS);
    last_ext_data = '0;
    $readmemh("testbench/soc_trace.txt", trace_mem);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // read_dn write_dn rw_halt ce_n oe_n we_n drive txd rx_received
    err0 = errors;
    tests++;
    check_value("reset levels", data_t'(9'b000111010),
                data_t'({read_dn, write_dn, rw_halt, sram_ce_n, sram_oe_n,
                         sram_we_n, sram_drive, txd, rx_received}));
    report_test("reset levels", err0);

    base = '0;
    while (base < 9'd505 && trace_mem[base] >= 32'd1 && trace_mem[base] <= 32'd5) begin
      op   = trace_mem[base];
      a    = trace_mem[base + 9'd1];
      d    = trace_mem[base + 9'd2];
      exp  = trace_mem[base + 9'd3];
      lat  = int'(trace_mem[base + 9'd4]);
      err0 = errors;
      case (op)
        32'd1: begin
          name = $sformatf("write %h", a);
          write_word(name, a, d, lat);
        end
        32'd2: begin
          name = $sformatf("read %h", a);
          read_word(name, a, exp, lat);
        end
        32'd3: begin
          name = $sformatf("send %h", d[7:0]);
          send_byte(name, d, exp, lat);
        end
        32'd4: begin
          name = $sformatf("receive %h", d[7:0]);
          receive_byte(name, d, exp, lat);
        end
        default: begin
          name = $sformatf("unmapped %h", a);
          probe_unmapped(name, a, exp);
        end
      endcase
      tests++;
      report_test(name, err0);
      base = base + 9'd5;
    end
    if (tests < 2) begin
      $display("trace file gave no operations");
      errors++;
    end

    errors = errors + pin_errors;
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/soc_assertions.sv
`timescale 1ns/10ps
`default_nettype none

// pin and bus protocol checks, bound into the program sram controller
module soc_assertions (
  input logic clk,
  input logic rst_n,
  input logic sram_ce_n,
  input logic sram_we_n,
  input logic sram_drive,
  input logic read_dn,
  input logic write_dn,
  input logic in_write    // sequencer sits in one of the write states
);

  // we pulse only inside a chip select
  we_inside_ce: assert property (@(posedge clk) disable iff (!rst_n)
    !sram_we_n |-> !sram_ce_n)
    else $error("sram we_n low while ce_n is high");

  one_done: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_dn && write_dn))
    else $error("read_dn and write_dn high in the same cycle");

  // data pins driven by the controller only while writing
  drive_in_write: assert property (@(posedge clk) disable iff (!rst_n)
    sram_drive |-> in_write)
    else $error("sram_drive high outside the write states");

endmodule

`default_nettype wire

// File: hw/soc_top.sv
`timescale 1ns/10ps
`default_nettype none

// peripheral bus with startup ram, program sram and rs232
module soc_top import bus_pkg::*; #(
  parameter int    INT_MEM_WORDS = DEF_INT_MEM_WORDS,
  parameter int    EXT_MEM_END   = DEF_EXT_MEM_END,
  parameter addr_t UART_ADDR     = DEF_UART_ADDR,
  parameter int    CLK_FREQ      = DEF_CLK_FREQ,
  parameter int    BAUD          = DEF_BAUD
) (
  input  logic       clk,
  input  logic       rst_n,
  // master side
  input  addr_t      addr,
  input  data_t      wdata,
  input  logic       read_q,
  input  logic       write_q,
  output data_t      rdata,
  output logic       read_dn,
  output logic       write_dn,
  output logic       rw_halt,
  // program sram pins
  output sram_addr_t sram_addr,
  output data_t      sram_wdata,
  input  data_t      sram_rdata,
  output logic       sram_ce_n,
  output logic       sram_oe_n,
  output logic       sram_we_n,
  output logic       sram_drive,
  // serial line
  input  logic       rxd,
  output logic       txd,
  output logic       rx_received
);

  mem_bus_if ram_bus ();
  mem_bus_if sram_bus ();
  mem_bus_if uart_bus ();

  // same request to every slave, each decodes its own range
  assign ram_bus.addr     = addr;
  assign ram_bus.wdata    = wdata;
  assign ram_bus.read_q   = read_q;
  assign ram_bus.write_q  = write_q;
  assign ram_bus.rw_halt  = rw_halt;
  assign sram_bus.addr    = addr;
  assign sram_bus.wdata   = wdata;
  assign sram_bus.read_q  = read_q;
  assign sram_bus.write_q = write_q;
  assign sram_bus.rw_halt = rw_halt;
  assign uart_bus.addr    = addr;
  assign uart_bus.wdata   = wdata;
  assign uart_bus.read_q  = read_q;
  assign uart_bus.write_q = write_q;
  assign uart_bus.rw_halt = rw_halt;

  startup_ram #(.INT_MEM_WORDS(INT_MEM_WORDS)) i_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (ram_bus)
  );

  sram_ctrl #(
    .INT_MEM_WORDS (INT_MEM_WORDS),
    .EXT_MEM_END   (EXT_MEM_END)
  ) i_sram (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (sram_bus),
    .sram_addr  (sram_addr),
    .sram_wdata (sram_wdata),
    .sram_rdata (sram_rdata),
    .sram_ce_n  (sram_ce_n),
    .sram_oe_n  (sram_oe_n),
    .sram_we_n  (sram_we_n),
    .sram_drive (sram_drive)
  );

  uart_port #(
    .UART_ADDR (UART_ADDR),
    .CLK_FREQ  (CLK_FREQ),
    .BAUD      (BAUD)
  ) i_uart (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (uart_bus),
    .rw_halt     (rw_halt),
    .rxd         (rxd),
    .txd         (txd),
    .rx_received (rx_received)
  );

  // idle slaves drive zeros, so a plain OR merges the responses
  assign rdata    = ram_bus.rdata | sram_bus.rdata | uart_bus.rdata;
  assign read_dn  = ram_bus.read_dn | sram_bus.read_dn | uart_bus.read_dn;
  assign write_dn = ram_bus.write_dn | sram_bus.write_dn | uart_bus.write_dn;

endmodule

`default_nettype wire

// File: hw/uart_port.sv
`timescale 1ns/10ps
`default_nettype none

// rs232 data register on the bus, one address for both directions
module uart_port import bus_pkg::*; #(
  parameter addr_t UART_ADDR = DEF_UART_ADDR,
  parameter int    CLK_FREQ  = DEF_CLK_FREQ,
  parameter int    BAUD      = DEF_BAUD
) (
  input  logic     clk,
  input  logic     rst_n,
  mem_bus_if.slave bus,
  output logic     rw_halt,       // high while a frame goes out
  input  logic     rxd,
  output logic     txd,
  output logic     rx_received    // byte waiting in the buffer
);

  localparam int CLKS_PER_BIT = CLK_FREQ / BAUD;

  byte_t rx_data;
  byte_t rx_buf;       // last received byte
  byte_t rdata_q;
  logic  rx_valid;
  logic  tx_busy;
  logic  tx_start;
  logic  rd_go;
  logic  read_dn_q;
  logic  write_dn_q;
  logic  sel;
  logic  guard;

  assign sel   = bus.addr == UART_ADDR;
  assign guard = read_dn_q | write_dn_q;
  assign rd_go = sel & bus.read_q & ~guard;
  // a write waits out the hold of the previous frame
  assign tx_start = sel & bus.write_q & ~bus.read_q & ~bus.rw_halt & ~guard;

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      rx_buf <= rx_data;
    end
    if (rd_go) begin
      rdata_q <= rx_buf;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_dn_q   <= 1'b0;
      write_dn_q  <= 1'b0;
      rx_received <= 1'b0;
    end else begin
      read_dn_q  <= rd_go;
      write_dn_q <= tx_start;   // rises with tx busy
      if (rx_valid) begin
        rx_received <= 1'b1;    // new byte beats a read on the same edge
      end else if (rd_go) begin
        rx_received <= 1'b0;
      end
    end
  end

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (bus.wdata[7:0]),
    .busy  (tx_busy),
    .txd   (txd)
  );

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rxd   (rxd),
    .data  (rx_data),
    .valid (rx_valid)
  );

  assign rw_halt      = tx_busy;
  assign bus.rdata    = read_dn_q ? {{(DATA_W-8){1'b0}}, rdata_q} : '0;
  assign bus.read_dn  = read_dn_q;
  assign bus.write_dn = write_dn_q;

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

// 8n1 receiver, samples in the middle of each bit
module uart_rx import bus_pkg::*; #(
  parameter int CLKS_PER_BIT = DEF_CLK_FREQ / DEF_BAUD
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rxd,
  output byte_t data,
  output logic  valid    // one cycle per good frame
);

  localparam int               CNT_W    = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic [2:0]       sync_q;    // two sync flops, then previous level
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_cnt;
  logic             line;
  logic             fall;
  logic             bit_tick;

  assign line     = sync_q[1];
  assign fall     = sync_q[2] & ~sync_q[1];   // start edge
  assign bit_tick = clk_cnt == FULL_BIT;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q  <= '1;
      state   <= RX_IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
      valid   <= 1'b0;
    end else begin
      sync_q <= {sync_q[1:0], rxd};
      valid  <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (clk_cnt == HALF_BIT) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= line ? RX_IDLE : RX_DATA;   // glitch back to idle
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end else begin
              bit_cnt <= bit_cnt + 3'd1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_tick) begin
            valid <= line;   // framing error drops the byte
            state <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // shift in at mid-bit, lsb arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_tick) begin
      data <= {line, data[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

// 8n1 transmitter, lsb first
module uart_tx import bus_pkg::*; #(
  parameter int CLKS_PER_BIT = DEF_CLK_FREQ / DEF_BAUD
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  byte_t data,
  output logic  busy,
  output logic  txd
);

  localparam int               CNT_W    = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  logic [9:0]       shreg;     // stop, data, start
  logic [CNT_W-1:0] clk_cnt;   // bit timer
  logic [3:0]       bit_cnt;   // 0 start .. 9 stop

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (clk_cnt == FULL_BIT) begin
      clk_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;   // stop bit done
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shreg <= {1'b1, data, 1'b0};
    end else if (busy && clk_cnt == FULL_BIT) begin
      shreg <= {1'b1, shreg[9:1]};   // next bit out
    end
  end

  assign txd = busy ? shreg[0] : 1'b1;   // line idles high

endmodule

`default_nettype wire

// File: hw/sram_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// external program sram with a seven-state read/write sequencer
module sram_ctrl import bus_pkg::*; #(
  parameter int INT_MEM_WORDS = DEF_INT_MEM_WORDS,
  parameter int EXT_MEM_END   = DEF_EXT_MEM_END
) (
  input  logic       clk,
  input  logic       rst_n,
  mem_bus_if.slave   bus,
  output sram_addr_t sram_addr,
  output data_t      sram_wdata,
  input  data_t      sram_rdata,
  output logic       sram_ce_n,
  output logic       sram_oe_n,
  output logic       sram_we_n,
  output logic       sram_drive   // enables the data pin drivers
);

  typedef enum logic [2:0] {
    ST_WAIT,
    ST_RD_SET_ADDR,
    ST_RD_DATA_GET,
    ST_RD_FINISH,
    ST_WR_SET_ADDR,
    ST_WR_SET_WE,
    ST_WR_FINISH
  } state_t;

  state_t state;
  addr_t  addr_q;      // latched bus address
  data_t  wdata_q;     // latched write word
  data_t  rdata_q;     // word taken from the pins
  logic   read_dn_q;
  logic   write_dn_q;
  logic   sel;
  logic   guard;

  // external range sits right above the startup ram
  assign sel   = (bus.addr >= addr_t'(INT_MEM_WORDS)) && (bus.addr < addr_t'(EXT_MEM_END));
  assign guard = read_dn_q | write_dn_q;

  // payload path
  always_ff @(posedge clk) begin
    if (state == ST_WAIT) begin
      addr_q  <= bus.addr;
      wdata_q <= bus.wdata;
    end
    if (state == ST_RD_SET_ADDR || state == ST_WR_SET_ADDR) begin
      sram_addr <= sram_addr_t'(addr_q - addr_t'(INT_MEM_WORDS));   // pin address from 0
    end
    if (state == ST_WR_SET_ADDR) begin
      sram_wdata <= wdata_q;
    end
    if (state == ST_RD_DATA_GET) begin
      rdata_q <= sram_rdata;   // ce/oe still low here
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_WAIT;
      read_dn_q  <= 1'b0;
      write_dn_q <= 1'b0;
      sram_ce_n  <= 1'b1;
      sram_oe_n  <= 1'b1;
      sram_we_n  <= 1'b1;
      sram_drive <= 1'b0;
    end else if (bus.rw_halt) begin
      // hold drops any access in flight without a done
      state      <= ST_WAIT;
      read_dn_q  <= 1'b0;
      write_dn_q <= 1'b0;
      sram_ce_n  <= 1'b1;
      sram_oe_n  <= 1'b1;
      sram_we_n  <= 1'b1;
      sram_drive <= 1'b0;
    end else begin
      read_dn_q  <= 1'b0;   // dones are single pulses
      write_dn_q <= 1'b0;
      case (state)
        ST_WAIT: begin
          if (sel && !guard && bus.read_q) begin
            state <= ST_RD_SET_ADDR;
          end else if (sel && !guard && bus.write_q) begin
            state <= ST_WR_SET_ADDR;
          end
        end
        ST_RD_SET_ADDR: begin
          sram_ce_n <= 1'b0;   // address goes out with ce
          sram_oe_n <= 1'b0;
          state     <= ST_RD_DATA_GET;
        end
        ST_RD_DATA_GET: begin
          read_dn_q <= 1'b1;
          sram_ce_n <= 1'b1;
          sram_oe_n <= 1'b1;
          state     <= ST_RD_FINISH;
        end
        ST_RD_FINISH: begin
          state <= ST_WAIT;   // master drops read_q on this edge
        end
        ST_WR_SET_ADDR: begin
          sram_ce_n  <= 1'b0;
          sram_drive <= 1'b1;   // data on the pins with the address
          state      <= ST_WR_SET_WE;
        end
        ST_WR_SET_WE: begin
          sram_we_n <= 1'b0;
          state     <= ST_WR_FINISH;
        end
        ST_WR_FINISH: begin
          sram_we_n  <= 1'b1;   // rising we stores the word
          sram_ce_n  <= 1'b1;
          sram_drive <= 1'b0;
          write_dn_q <= 1'b1;
          state      <= ST_WAIT;
        end
        default: state <= ST_WAIT;
      endcase
    end
  end

  assign bus.rdata    = read_dn_q ? rdata_q : '0;
  assign bus.read_dn  = read_dn_q;
  assign bus.write_dn = write_dn_q;

endmodule

`default_nettype wire

// File: hw/startup_ram.sv
`timescale 1ns/10ps
`default_nettype none

// small block ram at the bottom of the address space
module startup_ram import bus_pkg::*; #(
  parameter int INT_MEM_WORDS = DEF_INT_MEM_WORDS
) (
  input  logic     clk,
  input  logic     rst_n,
  mem_bus_if.slave bus
);

  localparam int IDX_W = $clog2(INT_MEM_WORDS);

  data_t            mem [INT_MEM_WORDS];
  data_t            rdata_q;      // read word, shown only with read_dn
  logic             read_dn_q;
  logic             write_dn_q;
  logic             sel;
  logic             guard;
  logic             rd_go;
  logic             wr_go;
  logic [IDX_W-1:0] idx;

  assign sel   = bus.addr < addr_t'(INT_MEM_WORDS);
  assign guard = read_dn_q | write_dn_q;   // request still up on the done edge
  assign idx   = bus.addr[IDX_W-1:0];

  // no new access under halt
  assign rd_go = sel & bus.read_q & ~bus.rw_halt & ~guard;
  assign wr_go = sel & bus.write_q & ~bus.read_q & ~bus.rw_halt & ~guard;   // read wins

  // array and read port
  always_ff @(posedge clk) begin
    if (wr_go) begin
      mem[idx] <= bus.wdata;
    end
    if (rd_go) begin
      rdata_q <= mem[idx];
    end
  end

  // done pulses, one cycle after the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_dn_q  <= 1'b0;
      write_dn_q <= 1'b0;
    end else begin
      read_dn_q  <= rd_go;
      write_dn_q <= wr_go;
    end
  end

  assign bus.rdata    = read_dn_q ? rdata_q : '0;   // zero when idle, ORed at top
  assign bus.read_dn  = read_dn_q;
  assign bus.write_dn = write_dn_q;

endmodule

`default_nettype wire

// File: hw/mem_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

// one bus request towards a slave and that slave's response
interface mem_bus_if import bus_pkg::*; ();

  // request, fanned out from the master ports
  addr_t addr;
  data_t wdata;
  logic  read_q;    // level, held until done
  logic  write_q;   // level, held until done
  logic  rw_halt;   // bus-wide hold from the rs232 port

  // response, all zero while the slave is not addressed
  data_t rdata;     // valid with read_dn only
  logic  read_dn;   // one-cycle pulse
  logic  write_dn;  // one-cycle pulse

  modport master (
    output addr, wdata, read_q, write_q, rw_halt,
    input  rdata, read_dn, write_dn
  );

  modport slave (
    input  addr, wdata, read_q, write_q, rw_halt,
    output rdata, read_dn, write_dn
  );

endinterface

`default_nettype wire

// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [7:0]        byte_t;   // one serial character

  // external program sram pins
  localparam int SRAM_ADDR_W = 18;

  typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

  // address map defaults, startup ram sits at zero
  localparam int    DEF_INT_MEM_WORDS = 256;   // also base of external sram
  localparam int    DEF_EXT_MEM_END   = DEF_INT_MEM_WORDS + 2**SRAM_ADDR_W;
  localparam addr_t DEF_UART_ADDR     = 32'hffff_fff0;

  // serial timing defaults
  localparam int DEF_CLK_FREQ = 50_000_000;
  localparam int DEF_BAUD     = 115_200;

endpackage

`default_nettype wire
